//--- pad_frame_pkg.sv
/* Pad map of the always-on frame. The index order must match the pad ring,
   and selects 2 and 3 both park a pad with its driver off. */

package pad_frame_pkg;

    localparam int unsigned NUM_PADS  = 10;
    localparam int unsigned PAD_CFG_W = 6;

    // **********************************************************************
    // Pad indices
    // **********************************************************************

    localparam int unsigned PAD_SPIM_SCK   = 0;
    localparam int unsigned PAD_SPIM_CSN0  = 1;
    localparam int unsigned PAD_SPIM_SDIO0 = 2;
    localparam int unsigned PAD_SPIM_SDIO1 = 3;
    localparam int unsigned PAD_SPIM_SDIO2 = 4;
    localparam int unsigned PAD_SPIM_SDIO3 = 5;
    localparam int unsigned PAD_UART_RX    = 6;
    localparam int unsigned PAD_UART_TX    = 7;
    localparam int unsigned PAD_I2C0_SDA   = 8;
    localparam int unsigned PAD_I2C0_SCL   = 9;

    // **********************************************************************
    // Function select and configuration
    // **********************************************************************

    typedef enum logic [1:0] {
        PAD_FUNC_PRIMARY = 2'd0,
        PAD_FUNC_GPIO    = 2'd1,
        PAD_FUNC_OFF0    = 2'd2,
        PAD_FUNC_OFF1    = 2'd3
    } pad_sel_e;

    // Drive strength and pull bits of one pad
    typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

    typedef pad_sel_e [NUM_PADS-1:0] pad_mux_t;
    typedef pad_cfg_t [NUM_PADS-1:0] pad_cfg_arr_t;

    // One bit per pad
    typedef logic [NUM_PADS-1:0] pad_bus_t;

endpackage

//--- periph_pkg.sv
/* Level bundles of the peripherals that own pads in primary mode.
   SPI mode value 3 is treated as quad receive. */

package periph_pkg;

    localparam int unsigned SPIM_DATA_W = 4;

    // **********************************************************************
    // Quad SPI master
    // **********************************************************************

    typedef enum logic [1:0] {
        SPIM_STD     = 2'd0,
        SPIM_QUAD_TX = 2'd1,
        SPIM_QUAD_RX = 2'd2
    } spim_mode_e;

    typedef struct packed {
        spim_mode_e             mode;
        logic                   sck;
        logic                   csn0;
        logic [SPIM_DATA_W-1:0] sdo;
    } spim_out_t;

    typedef logic [SPIM_DATA_W-1:0] spim_in_t;

    // **********************************************************************
    // UART
    // **********************************************************************

    typedef struct packed {
        logic tx;
    } uart_out_t;

    typedef struct packed {
        logic rx;
    } uart_in_t;

    // **********************************************************************
    // I2C, open drain
    // **********************************************************************

    typedef struct packed {
        logic scl_out;
        logic scl_oe;
        logic sda_out;
        logic sda_oe;
    } i2c_out_t;

    typedef struct packed {
        logic scl_in;
        logic sda_in;
    } i2c_in_t;

endpackage

//--- rst_sync.sv
/* Reset for logic on ref_clk_i. Assert is asynchronous, release comes
   on the second rising edge after rst_ni goes high. */

module rst_sync (
    input  logic ref_clk_i,
    input  logic rst_ni,
    output logic rst_no
);

    logic [1:0] sync_q;

    always_ff @(posedge ref_clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign rst_no = sync_q[1];

    // Output reset may never be released while the input is held
    a_no_early_release : assert property (
        @(posedge ref_clk_i) !rst_ni |-> !rst_no
    ) else $error("rst_no high while rst_ni low");

endmodule

//--- pad_out_mux.sv
/* Purely combinational. Pad out values on pads with oe low are don't care
   for the ring; SPI data pads carry sdo even when not driven. */

module pad_out_mux (
    input  periph_pkg::spim_out_t       spim_i,
    input  periph_pkg::uart_out_t       uart_i,
    input  periph_pkg::i2c_out_t        i2c0_i,
    input  pad_frame_pkg::pad_bus_t     gpio_out_i,
    input  pad_frame_pkg::pad_bus_t     gpio_dir_i,
    input  pad_frame_pkg::pad_cfg_arr_t gpio_cfg_i,
    input  pad_frame_pkg::pad_mux_t     pad_mux_i,
    input  pad_frame_pkg::pad_cfg_arr_t pad_cfg_i,
    output pad_frame_pkg::pad_bus_t     pad_out_o,
    output pad_frame_pkg::pad_bus_t     pad_oe_o,
    output pad_frame_pkg::pad_cfg_arr_t pad_cfg_o
);

    import pad_frame_pkg::*;
    import periph_pkg::*;

    pad_bus_t               prim_out;
    pad_bus_t               prim_oe;
    logic [SPIM_DATA_W-1:0] sdio_oe;

    // **********************************************************************
    // Primary functions
    // **********************************************************************

    // SPI data pad direction
    always_comb begin
        case (spim_i.mode)
            SPIM_STD:     sdio_oe = 4'b0001;
            SPIM_QUAD_TX: sdio_oe = 4'b1111;
            default:      sdio_oe = 4'b0000;
        endcase
    end

    always_comb begin
        prim_out = '0;
        prim_oe  = '0;

        prim_out[PAD_SPIM_SCK]  = spim_i.sck;
        prim_oe[PAD_SPIM_SCK]   = 1'b1;
        prim_out[PAD_SPIM_CSN0] = spim_i.csn0;
        prim_oe[PAD_SPIM_CSN0]  = 1'b1;

        for (int k = 0; k < SPIM_DATA_W; k++) begin
            prim_out[PAD_SPIM_SDIO0 + k] = spim_i.sdo[k];
            prim_oe[PAD_SPIM_SDIO0 + k]  = sdio_oe[k];
        end

        // RX stays an input
        prim_out[PAD_UART_TX] = uart_i.tx;
        prim_oe[PAD_UART_TX]  = 1'b1;

        prim_out[PAD_I2C0_SDA] = i2c0_i.sda_out;
        prim_oe[PAD_I2C0_SDA]  = i2c0_i.sda_oe;
        prim_out[PAD_I2C0_SCL] = i2c0_i.scl_out;
        prim_oe[PAD_I2C0_SCL]  = i2c0_i.scl_oe;
    end

    // **********************************************************************
    // Per pad function select
    // **********************************************************************

    always_comb begin
        for (int p = 0; p < NUM_PADS; p++) begin
            pad_cfg_o[p] = pad_cfg_i[p];
            case (pad_mux_i[p])
                PAD_FUNC_PRIMARY: begin
                    pad_out_o[p] = prim_out[p];
                    pad_oe_o[p]  = prim_oe[p];
                end
                PAD_FUNC_GPIO: begin
                    pad_out_o[p] = gpio_out_i[p];
                    pad_oe_o[p]  = gpio_dir_i[p];
                    pad_cfg_o[p] = gpio_cfg_i[p];
                end
                default: begin
                    pad_out_o[p] = 1'b0;
                    pad_oe_o[p]  = 1'b0;
                end
            endcase
        end
    end

    // Off pads never drive, whatever the peripherals request
    always_comb begin
        for (int p = 0; p < NUM_PADS; p++) begin
            if (pad_mux_i[p] inside {PAD_FUNC_OFF0, PAD_FUNC_OFF1}) begin
                a_off_no_oe : assert final (!pad_oe_o[p])
                    else $error("pad %0d is off but has oe set", p);
            end
        end
    end

endmodule

//--- pad_in_route.sv
/* Purely combinational. Inputs of pads that are not in primary mode are
   hidden from the peripherals, which then see their idle level. */

module pad_in_route (
    input  pad_frame_pkg::pad_bus_t  pad_in_i,
    input  pad_frame_pkg::pad_mux_t  pad_mux_i,
    input  periph_pkg::spim_mode_e   spim_mode_i,
    output periph_pkg::spim_in_t     spim_o,
    output periph_pkg::uart_in_t     uart_o,
    output periph_pkg::i2c_in_t      i2c0_o,
    output pad_frame_pkg::pad_bus_t  gpio_in_o
);

    import pad_frame_pkg::*;
    import periph_pkg::*;

    pad_bus_t prim_en;
    pad_bus_t gpio_en;

    always_comb begin
        for (int p = 0; p < NUM_PADS; p++) begin
            prim_en[p] = (pad_mux_i[p] == PAD_FUNC_PRIMARY);
            gpio_en[p] = (pad_mux_i[p] == PAD_FUNC_GPIO);
        end
    end

    // **********************************************************************
    // GPIO
    // **********************************************************************

    assign gpio_in_o = pad_in_i & gpio_en;

    // **********************************************************************
    // UART and I2C, idle high
    // **********************************************************************

    assign uart_o.rx = prim_en[PAD_UART_RX] ? pad_in_i[PAD_UART_RX] : 1'b1;

    assign i2c0_o.scl_in = prim_en[PAD_I2C0_SCL] ? pad_in_i[PAD_I2C0_SCL] : 1'b1;
    assign i2c0_o.sda_in = prim_en[PAD_I2C0_SDA] ? pad_in_i[PAD_I2C0_SDA] : 1'b1;

    // **********************************************************************
    // Quad SPI, idle low
    // **********************************************************************

    always_comb begin
        spim_o = '0;
        case (spim_mode_i)
            // Single line mode reads MISO on SDIO1
            SPIM_STD: begin
                spim_o[0] = prim_en[PAD_SPIM_SDIO1] & pad_in_i[PAD_SPIM_SDIO1];
            end
            SPIM_QUAD_TX: begin
                spim_o = '0;
            end
            default: begin
                for (int k = 0; k < SPIM_DATA_W; k++) begin
                    spim_o[k] = prim_en[PAD_SPIM_SDIO0 + k] & pad_in_i[PAD_SPIM_SDIO0 + k];
                end
            end
        endcase
    end

endmodule

//--- pad_control.sv
/* Pad controller as seen by the SoC. No state, so every pad path is
   combinational from select, peripheral and pad input. */

module pad_control (
    input  periph_pkg::spim_out_t       spim_i,
    input  periph_pkg::uart_out_t       uart_i,
    input  periph_pkg::i2c_out_t        i2c0_i,
    input  pad_frame_pkg::pad_bus_t     gpio_out_i,
    input  pad_frame_pkg::pad_bus_t     gpio_dir_i,
    input  pad_frame_pkg::pad_cfg_arr_t gpio_cfg_i,
    input  pad_frame_pkg::pad_mux_t     pad_mux_i,
    input  pad_frame_pkg::pad_cfg_arr_t pad_cfg_i,
    output pad_frame_pkg::pad_bus_t     pad_out_o,
    output pad_frame_pkg::pad_bus_t     pad_oe_o,
    output pad_frame_pkg::pad_cfg_arr_t pad_cfg_o,
    input  pad_frame_pkg::pad_bus_t     pad_in_i,
    output periph_pkg::spim_in_t        spim_o,
    output periph_pkg::uart_in_t        uart_o,
    output periph_pkg::i2c_in_t         i2c0_o,
    output pad_frame_pkg::pad_bus_t     gpio_in_o
);

    pad_out_mux u_pad_out_mux (
        .spim_i     ( spim_i     ),
        .uart_i     ( uart_i     ),
        .i2c0_i     ( i2c0_i     ),
        .gpio_out_i ( gpio_out_i ),
        .gpio_dir_i ( gpio_dir_i ),
        .gpio_cfg_i ( gpio_cfg_i ),
        .pad_mux_i  ( pad_mux_i  ),
        .pad_cfg_i  ( pad_cfg_i  ),
        .pad_out_o  ( pad_out_o  ),
        .pad_oe_o   ( pad_oe_o   ),
        .pad_cfg_o  ( pad_cfg_o  )
    );

    // SPI mode steers the input mapping as well as the pad direction
    pad_in_route u_pad_in_route (
        .pad_in_i    ( pad_in_i    ),
        .pad_mux_i   ( pad_mux_i   ),
        .spim_mode_i ( spim_i.mode ),
        .spim_o      ( spim_o      ),
        .uart_o      ( uart_o      ),
        .i2c0_o      ( i2c0_o      ),
        .gpio_in_o   ( gpio_in_o   )
    );

endmodule

//--- safe_domain.sv
/* Always-on domain. Only rst_no is synchronized; the pad outputs carry no
   state and do not depend on reset. */

module safe_domain (
    input  logic                        ref_clk_i,
    input  logic                        rst_ni,
    output logic                        slow_clk_o,
    output logic                        rst_no,

    input  periph_pkg::spim_out_t       spim_i,
    input  periph_pkg::uart_out_t       uart_i,
    input  periph_pkg::i2c_out_t        i2c0_i,
    input  pad_frame_pkg::pad_bus_t     gpio_out_i,
    input  pad_frame_pkg::pad_bus_t     gpio_dir_i,
    input  pad_frame_pkg::pad_cfg_arr_t gpio_cfg_i,
    input  pad_frame_pkg::pad_mux_t     pad_mux_i,
    input  pad_frame_pkg::pad_cfg_arr_t pad_cfg_i,
    output pad_frame_pkg::pad_bus_t     pad_out_o,
    output pad_frame_pkg::pad_bus_t     pad_oe_o,
    output pad_frame_pkg::pad_cfg_arr_t pad_cfg_o,
    input  pad_frame_pkg::pad_bus_t     pad_in_i,
    output periph_pkg::spim_in_t        spim_o,
    output periph_pkg::uart_in_t        uart_o,
    output periph_pkg::i2c_in_t         i2c0_o,
    output pad_frame_pkg::pad_bus_t     gpio_in_o
);

    // **********************************************************************
    // Clock and reset
    // **********************************************************************

    // Slow clock is the reference clock itself
    assign slow_clk_o = ref_clk_i;

    rst_sync u_rst_sync (
        .ref_clk_i ( ref_clk_i ),
        .rst_ni    ( rst_ni    ),
        .rst_no    ( rst_no    )
    );

    // **********************************************************************
    // Pads
    // **********************************************************************

    pad_control u_pad_control (
        .spim_i     ( spim_i     ),
        .uart_i     ( uart_i     ),
        .i2c0_i     ( i2c0_i     ),
        .gpio_out_i ( gpio_out_i ),
        .gpio_dir_i ( gpio_dir_i ),
        .gpio_cfg_i ( gpio_cfg_i ),
        .pad_mux_i  ( pad_mux_i  ),
        .pad_cfg_i  ( pad_cfg_i  ),
        .pad_out_o  ( pad_out_o  ),
        .pad_oe_o   ( pad_oe_o   ),
        .pad_cfg_o  ( pad_cfg_o  ),
        .pad_in_i   ( pad_in_i   ),
        .spim_o     ( spim_o     ),
        .uart_o     ( uart_o     ),
        .i2c0_o     ( i2c0_o     ),
        .gpio_in_o  ( gpio_in_o  )
    );

endmodule

//--- tb_safe_domain.sv
/* Random and swept stimulus on the pad controller, checked by assertions at the
   falling edge. Pad out values with oe low are only checked where the rule fixes them. */

module tb_safe_domain;

    timeunit 1ns;
    timeprecision 100ps;

    import pad_frame_pkg::*;
    import periph_pkg::*;

    localparam int unsigned NUM_CYCLES = 200;
    localparam int unsigned MAX_CYCLES = 2 * NUM_CYCLES;
    localparam int unsigned SWEEP_LEN  = 16;

    logic         ref_clk;
    logic         rst_ni;
    logic         slow_clk_o;
    logic         rst_no;
    spim_out_t    spim_out;
    uart_out_t    uart_out;
    i2c_out_t     i2c0_out;
    pad_bus_t     gpio_out;
    pad_bus_t     gpio_dir;
    pad_cfg_arr_t gpio_cfg;
    pad_mux_t     pad_mux;
    pad_cfg_arr_t pad_cfg;
    pad_bus_t     pad_out;
    pad_bus_t     pad_oe;
    pad_cfg_arr_t pad_cfg_q;
    pad_bus_t     pad_in;
    spim_in_t     spim_in;
    uart_in_t     uart_in;
    i2c_in_t      i2c0_in;
    pad_bus_t     gpio_in;

    logic [31:0]  lfsr_state;
    int unsigned  err_cnt;
    int unsigned  cycle_cnt;

    // Expected responses
    pad_bus_t     exp_out;
    pad_bus_t     exp_oe;
    pad_bus_t     out_care;
    pad_cfg_arr_t exp_cfg;
    pad_bus_t     exp_gpio_in;
    spim_in_t     exp_sdi;
    logic         exp_rx;
    logic         exp_scl;
    logic         exp_sda;
    int unsigned  rel_edges;
    logic         exp_rst;

    safe_domain u_dut (
        .ref_clk_i  ( ref_clk    ),
        .rst_ni     ( rst_ni     ),
        .slow_clk_o ( slow_clk_o ),
        .rst_no     ( rst_no     ),
        .spim_i     ( spim_out   ),
        .uart_i     ( uart_out   ),
        .i2c0_i     ( i2c0_out   ),
        .gpio_out_i ( gpio_out   ),
        .gpio_dir_i ( gpio_dir   ),
        .gpio_cfg_i ( gpio_cfg   ),
        .pad_mux_i  ( pad_mux    ),
        .pad_cfg_i  ( pad_cfg    ),
        .pad_out_o  ( pad_out    ),
        .pad_oe_o   ( pad_oe     ),
        .pad_cfg_o  ( pad_cfg_q  ),
        .pad_in_i   ( pad_in     ),
        .spim_o     ( spim_in    ),
        .uart_o     ( uart_in    ),
        .i2c0_o     ( i2c0_in    ),
        .gpio_in_o  ( gpio_in    )
    );

    initial begin
        ref_clk = 1'b0;
        forever #5 ref_clk = ~ref_clk;
    end

    // **********************************************************************
    // Reference model
    // **********************************************************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic spi_data_driven(input spim_mode_e mode, input int k);
        case (mode)
            SPIM_STD:     return (k == 0);
            SPIM_QUAD_TX: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    // Pad that feeds sdi bit k, or -1 when the bit reads 0
    function automatic int spi_sdi_pad(input spim_mode_e mode, input int k);
        case (mode)
            SPIM_STD:     return (k == 0) ? int'(PAD_SPIM_SDIO1) : -1;
            SPIM_QUAD_TX: return -1;
            default:      return int'(PAD_SPIM_SDIO0) + k;
        endcase
    endfunction

    // Returns {oe, out} of the primary function on pad p
    function automatic logic [1:0] primary_drive(input int p, input spim_out_t s,
                                                 input uart_out_t u, input i2c_out_t c);
        int k;
        k = p - int'(PAD_SPIM_SDIO0);
        if (p == int'(PAD_SPIM_SCK))
            return {1'b1, s.sck};
        if (p == int'(PAD_SPIM_CSN0))
            return {1'b1, s.csn0};
        if (k >= 0 && k < 4)
            return {spi_data_driven(s.mode, k), s.sdo[k]};
        if (p == int'(PAD_UART_TX))
            return {1'b1, u.tx};
        if (p == int'(PAD_I2C0_SDA))
            return {c.sda_oe, c.sda_out};
        if (p == int'(PAD_I2C0_SCL))
            return {c.scl_oe, c.scl_out};
        return 2'b00;
    endfunction

    always_comb begin : ref_model
        logic [1:0] drv;
        int         idx;
        exp_out     = '0;
        exp_oe      = '0;
        out_care    = '0;
        exp_gpio_in = '0;
        exp_sdi     = '0;
        exp_cfg     = pad_cfg;
        for (int p = 0; p < NUM_PADS; p++) begin
            drv = primary_drive(p, spim_out, uart_out, i2c0_out);
            if (pad_mux[p] == PAD_FUNC_PRIMARY) begin
                exp_out[p]  = drv[0];
                exp_oe[p]   = drv[1];
                out_care[p] = drv[1];
            end else if (pad_mux[p] == PAD_FUNC_GPIO) begin
                exp_out[p]     = gpio_out[p];
                exp_oe[p]      = gpio_dir[p];
                out_care[p]    = 1'b1;
                exp_cfg[p]     = gpio_cfg[p];
                exp_gpio_in[p] = pad_in[p];
            end else begin
                out_care[p] = 1'b1;
            end
        end
        for (int k = 0; k < 4; k++) begin
            idx = spi_sdi_pad(spim_out.mode, k);
            if (idx >= 0 && pad_mux[idx] == PAD_FUNC_PRIMARY)
                exp_sdi[k] = pad_in[idx];
        end
        exp_rx  = (pad_mux[PAD_UART_RX] == PAD_FUNC_PRIMARY) ? pad_in[PAD_UART_RX] : 1'b1;
        exp_scl = (pad_mux[PAD_I2C0_SCL] == PAD_FUNC_PRIMARY) ? pad_in[PAD_I2C0_SCL] : 1'b1;
        exp_sda = (pad_mux[PAD_I2C0_SDA] == PAD_FUNC_PRIMARY) ? pad_in[PAD_I2C0_SDA] : 1'b1;
    end

    // Released reset is expected two rising edges after rst_ni goes high
    always @(posedge ref_clk or negedge rst_ni) begin
        if (!rst_ni)
            rel_edges <= 0;
        else if (rel_edges < 2)
            rel_edges <= rel_edges + 1;
    end

    assign exp_rst = (rel_edges == 2);

    // **********************************************************************
    // Checks
    // **********************************************************************

    a_rst : assert property (@(negedge ref_clk) rst_no == exp_rst) else begin
        err_cnt++;
        $display("[FAIL] rst_no: expected %b actual %b", exp_rst, rst_no);
    end

    a_pad_out : assert property (@(negedge ref_clk)
        (pad_out & out_care) == (exp_out & out_care)) else begin
        err_cnt++;
        $display("[FAIL] pad_out: expected %h actual %h (mask %h)",
                 exp_out & out_care, pad_out & out_care, out_care);
    end

    a_pad_oe : assert property (@(negedge ref_clk) pad_oe == exp_oe) else begin
        err_cnt++;
        $display("[FAIL] pad_oe: expected %h actual %h", exp_oe, pad_oe);
    end

    a_pad_cfg : assert property (@(negedge ref_clk) pad_cfg_q == exp_cfg) else begin
        err_cnt++;
        $display("[FAIL] pad_cfg: expected %h actual %h", exp_cfg, pad_cfg_q);
    end

    a_gpio_in : assert property (@(negedge ref_clk) gpio_in == exp_gpio_in) else begin
        err_cnt++;
        $display("[FAIL] gpio_in: expected %h actual %h", exp_gpio_in, gpio_in);
    end

    a_spim_in : assert property (@(negedge ref_clk) spim_in == exp_sdi) else begin
        err_cnt++;
        $display("[FAIL] spim_sdi mode %0d: expected %h actual %h",
                 spim_out.mode, exp_sdi, spim_in);
    end

    a_uart_in : assert property (@(negedge ref_clk) uart_in.rx == exp_rx) else begin
        err_cnt++;
        $display("[FAIL] uart_rx: expected %b actual %b", exp_rx, uart_in.rx);
    end

    a_i2c_in : assert property (@(negedge ref_clk)
        i2c0_in == {exp_scl, exp_sda}) else begin
        err_cnt++;
        $display("[FAIL] i2c0_in: expected %b actual %b", {exp_scl, exp_sda}, i2c0_in);
    end

    // Slow clock checked in the middle of each clock phase
    always @(ref_clk) begin
        #2;
        a_slow_clk : assert (slow_clk_o === ref_clk) else begin
            err_cnt++;
            $display("[FAIL] slow_clk: expected %b actual %b", ref_clk, slow_clk_o);
        end
    end

    // **********************************************************************
    // Stimulus
    // **********************************************************************

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_random();
        logic [63:0] v;
        rand_bits(2 * NUM_PADS, v);
        pad_mux = pad_mux_t'(v[2*NUM_PADS-1:0]);
        rand_bits(8, v);
        spim_out = spim_out_t'(v[7:0]);
        rand_bits(1, v);
        uart_out = uart_out_t'(v[0]);
        rand_bits(4, v);
        i2c0_out = i2c_out_t'(v[3:0]);
        rand_bits(NUM_PADS, v);
        gpio_out = v[NUM_PADS-1:0];
        rand_bits(NUM_PADS, v);
        gpio_dir = v[NUM_PADS-1:0];
        rand_bits(NUM_PADS * PAD_CFG_W, v);
        gpio_cfg = pad_cfg_arr_t'(v[NUM_PADS*PAD_CFG_W-1:0]);
        rand_bits(NUM_PADS * PAD_CFG_W, v);
        pad_cfg = pad_cfg_arr_t'(v[NUM_PADS*PAD_CFG_W-1:0]);
        rand_bits(NUM_PADS, v);
        pad_in = v[NUM_PADS-1:0];
    endtask

    // All pads on one select, every SPI mode code
    task automatic drive_sweep(input logic [3:0] step);
        drive_random();
        pad_mux = pad_mux_t'({NUM_PADS{step[1:0]}});
        spim_out.mode = spim_mode_e'(step[3:2]);
    endtask

    always @(posedge ref_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        lfsr_state = 32'h98fe;
        err_cnt    = 0;
        cycle_cnt  = 0;
        rst_ni     = 1'b0;
        spim_out   = '0;
        uart_out   = '0;
        i2c0_out   = '0;
        gpio_out   = '0;
        gpio_dir   = '0;
        gpio_cfg   = '0;
        pad_mux    = '0;
        pad_cfg    = '0;
        pad_in     = '0;

        repeat (3) @(posedge ref_clk);
        #1 rst_ni = 1'b1;

        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge ref_clk);
            #1;
            if (i < SWEEP_LEN)
                drive_sweep(4'(i));
            else
                drive_random();
            // Short reset pulse in the middle of the run
            if (i == 100)
                rst_ni = 1'b0;
            if (i == 102)
                rst_ni = 1'b1;
        end
        repeat (2) @(posedge ref_clk);

        $display("Checks done after %0d cycles: %0d errors", cycle_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- src.f
pad_frame_pkg.sv
periph_pkg.sv
rst_sync.sv
pad_out_mux.sv
pad_in_route.sv
pad_control.sv
safe_domain.sv
tb_safe_domain.sv

//--- Makefile
SIM       ?= verilator
TOP       ?= tb_safe_domain
FILELIST  ?= src.f
SIMFLAGS  ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  := TB PASSED

SOURCES := $(shell cat $(FILELIST))
BINARY  := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
